// ==== tb.f ====
+incdir+include
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/fetch_unit.sv
rtl/instr_decoder.sv
rtl/reg_datapath.sv
rtl/cpu_top.sv
bench/tb_cpu.sv

// ==== include/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH
`default_nettype none

//////////////////////////////////////////////////
// checking and random numbers

task automatic check(input string name, input word_t got, input word_t exp);
  check_count++;
  if (got !== exp) begin
    $display("ERR %s got 0x%02h expected 0x%02h", name, got, exp);
    err_count++;
  end
endtask

// 32-bit LCG, middle byte taken as the value
function automatic word_t next_random();
  rand_state = rand_state * 32'd1103515245 + 32'd12345;
  return rand_state[23:16];
endfunction

task automatic report_test(input string name, input int errs_before);
  test_count++;
  if (err_count == errs_before) begin
    $display("test %s: passed", name);
  end else begin
    fail_tests++;
    $display("test %s: failed with %0d errors", name, err_count - errs_before);
  end
endtask

//////////////////////////////////////////////////
// DUT control, all driven on the falling edge

task automatic reset_dut();
  @(negedge clk);
  arst_n = 1'b0;
  uio_in = '0;
  ui_in  = '0;
  repeat (3) @(negedge clk);
  arst_n = 1'b1;
endtask

task automatic clear_program();
  for (int i = 0; i < PROG_DEPTH; i++) begin
    prog[i] = {NOP, 4'h0};
  end
endtask

// write strobe is bits 5:4 = 01 with run low
task automatic load_program();
  for (int i = 0; i < PROG_DEPTH; i++) begin
    @(negedge clk);
    uio_in = {4'b0001, nib_t'(i)};
    ui_in  = prog[i];
  end
  @(negedge clk);
  uio_in = '0;
  ui_in  = '0;
endtask

// exactly n rising edges with run high
task automatic run_cycles(input int n);
  @(negedge clk);
  uio_in = 8'h80;
  repeat (n) @(negedge clk);
  uio_in = 8'h00;
endtask

task automatic run_until(input word_t exp, input int limit);
  bit found;
  found = 1'b0;
  @(negedge clk);
  uio_in = 8'h80;
  for (int n = 0; n < limit && !found; n++) begin
    @(negedge clk);
    if (uo_out === exp) begin
      found = 1'b1;
    end
  end
  uio_in = 8'h00;
  if (!found) begin
    $display("timeout, uo_out did not reach 0x%02h within %0d cycles", exp, limit);
    err_count++;
  end
endtask

`default_nettype wire
`endif

// ==== bench/tb_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu
  import cpu_pkg::*;
();

  logic        clk;
  logic        arst_n;
  word_t       ui_in;
  word_t       uio_in;
  word_t       uo_out;
  word_t       uio_out;
  word_t       uio_oe;

  word_t       prog [PROG_DEPTH];
  int          err_count;
  int          check_count;
  int          test_count;
  int          fail_tests;
  logic [31:0] rand_state;

  cpu_top i_dut (
    .ui_in   (ui_in),
    .uo_out  (uo_out),
    .uio_in  (uio_in),
    .uio_out (uio_out),
    .uio_oe  (uio_oe),
    .clk     (clk),
    .arst_n  (arst_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // directed tests

  task automatic test_reset();
    int errs;
    errs = err_count;
    reset_dut();
    check("uo_out", uo_out, 8'h00);
    check("uio_out", uio_out, 8'h00);
    check("uio_oe", uio_oe, 8'h00);
    clear_program();
    prog[0] = {OUT, 4'd0};
    load_program();
    run_cycles(1);
    check("uo_out", uo_out, 8'h00);
    report_test("reset", errs);
  endtask

  // each nibble load followed by OUT of the same register
  task automatic test_nibble_loads();
    int   errs;
    nib_t lo [3];
    nib_t hi [3];
    errs = err_count;
    reset_dut();
    clear_program();
    for (int r = 0; r < 3; r++) begin
      lo[r] = nib_t'(3 + 5 * r);
      hi[r] = nib_t'(12 - 3 * r);
      prog[4*r]   = {nib_t'(1 + 2 * r), lo[r]};
      prog[4*r+1] = {OUT, nib_t'(r)};
      prog[4*r+2] = {nib_t'(2 + 2 * r), hi[r]};
      prog[4*r+3] = {OUT, nib_t'(r)};
    end
    load_program();
    for (int r = 0; r < 3; r++) begin
      run_cycles(2);
      check("uo_out", uo_out, {4'h0, lo[r]});
      run_cycles(2);
      check("uo_out", uo_out, {hi[r], lo[r]});
    end
    report_test("nibble_loads", errs);
  endtask

  task automatic test_alu();
    int    errs;
    word_t a;
    word_t b;
    int    sum;
    int    diff;
    int    prod;
    errs = err_count;
    a    = next_random();
    b    = next_random();
    // expected results wrap modulo 256
    sum  = (int'(a) + int'(b)) % 256;
    diff = (int'(a) - int'(b) + 256) % 256;
    prod = (int'(a) * int'(b)) % 256;
    reset_dut();
    clear_program();
    prog[0] = {LDA_LO, a[3:0]};
    prog[1] = {LDA_HI, a[7:4]};
    prog[2] = {LDB_LO, b[3:0]};
    prog[3] = {LDB_HI, b[7:4]};
    prog[4] = {ADD, 4'h0};
    prog[5] = {OUT, 4'd2};
    prog[6] = {SUB, 4'h0};
    prog[7] = {OUT, 4'd2};
    prog[8] = {MUL, 4'h0};
    prog[9] = {OUT, 4'd2};
    load_program();
    run_cycles(6);
    check("uo_out", uo_out, word_t'(sum));
    run_cycles(2);
    check("uo_out", uo_out, word_t'(diff));
    run_cycles(2);
    check("uo_out", uo_out, word_t'(prod));
    report_test("alu", errs);
  endtask

  task automatic test_in_port();
    int    errs;
    word_t v;
    errs = err_count;
    v    = next_random();
    // a zero value would match uo_out straight after reset
    if (v == 8'h00) begin
      v = 8'h5a;
    end
    reset_dut();
    clear_program();
    prog[0] = {IN, 4'd1};
    prog[1] = {OUT, 4'd1};
    load_program();
    @(negedge clk);
    ui_in = v;
    run_until(v, 8);
    check("uo_out", uo_out, v);
    report_test("in_port", errs);
  endtask

  task automatic test_idle_and_gating();
    int errs;
    errs = err_count;
    reset_dut();
    clear_program();
    prog[0]  = {LDA_LO, 4'h6};
    prog[1]  = {LDA_HI, 4'h9};
    prog[2]  = {OUT, 4'd0};
    prog[3]  = {NOP, 4'h0};
    prog[4]  = 8'hc0;
    prog[5]  = 8'hd5;
    prog[6]  = 8'he7;
    prog[7]  = 8'hff;
    prog[8]  = {IN, 4'd3};
    prog[9]  = {OUT, 4'd3};
    prog[10] = {LDB_LO, 4'h4};
    prog[11] = {OUT, 4'd1};
    prog[12] = {LDB_HI, 4'ha};
    prog[13] = {OUT, 4'd1};
    prog[14] = {OUT, 4'd2};
    load_program();
    @(negedge clk);
    ui_in = 8'h5a;
    run_cycles(3);
    check("uo_out", uo_out, 8'h96);
    run_cycles(8);
    check("uo_out", uo_out, 8'h96);
    // stopped in front of OUT B, nothing executes and pc stays at 11
    repeat (4) @(negedge clk);
    check("uo_out", uo_out, 8'h96);
    // write strobe to address 13 while running is ignored
    @(negedge clk);
    uio_in = 8'h9d;
    ui_in  = {OUT, 4'd0};
    repeat (2) @(negedge clk);
    uio_in = 8'h00;
    check("uo_out", uo_out, 8'h04);
    run_cycles(1);
    check("uo_out", uo_out, 8'ha4);
    // C untouched by the IN with select 3
    run_cycles(1);
    check("uo_out", uo_out, 8'h00);
    report_test("idle_and_gating", errs);
  endtask

  initial begin
    arst_n      = 1'b0;
    ui_in       = '0;
    uio_in      = '0;
    err_count   = 0;
    check_count = 0;
    test_count  = 0;
    fail_tests  = 0;
    rand_state  = 32'd48549;
    test_reset();
    test_nibble_loads();
    test_alu();
    test_in_port();
    test_idle_and_gating();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_count, fail_tests, check_count, err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  `include "tb_tasks.svh"

endmodule

`default_nettype wire

// ==== rtl/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top
  import cpu_pkg::*;
(
  input  word_t ui_in,
  output word_t uo_out,
  input  word_t uio_in,
  output word_t uio_out,
  output word_t uio_oe,
  input  logic  clk,
  input  logic  arst_n
);

  word_t instr;
  logic  instr_valid;
  exec_t exec;
  word_t reg_a;
  word_t reg_b;
  word_t alu_result;

  // bidirectional pins are never driven, control arrives on uio_in
  assign uio_out = '0;
  assign uio_oe  = '0;

  //////////////////////////////////////////////////
  // fetch, decode, execute

  fetch_unit i_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .uio_in      (uio_in),
    .ui_in       (ui_in),
    .instr       (instr),
    .instr_valid (instr_valid)
  );

  instr_decoder i_decoder (
    .instr       (instr),
    .instr_valid (instr_valid),
    .exec        (exec)
  );

  alu i_alu (
    .a      (reg_a),
    .b      (reg_b),
    .op     (exec.alu_op),
    .result (alu_result)
  );

  reg_datapath i_datapath (
    .clk        (clk),
    .arst_n     (arst_n),
    .exec       (exec),
    .ui_in      (ui_in),
    .alu_result (alu_result),
    .reg_a      (reg_a),
    .reg_b      (reg_b),
    .uo_out     (uo_out)
  );

endmodule

`default_nettype wire

// ==== rtl/reg_datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_datapath
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  exec_t exec,
  input  word_t ui_in,
  input  word_t alu_result,
  output word_t reg_a,
  output word_t reg_b,
  output word_t uo_out
);

  word_t reg_c;
  word_t a_next;
  word_t b_next;
  word_t c_next;
  word_t out_sel;

  //////////////////////////////////////////////////
  // next value of one register for the current exec

  function automatic word_t next_val(
    input word_t    cur,
    input reg_sel_e self,
    input exec_t    ex,
    input word_t    din,
    input word_t    alu_in
  );
    word_t nxt;
    nxt = cur;
    if (ex.target == self) begin
      // a nibble load leaves the other half alone
      if (ex.ld_lo) begin
        nxt[NIB_W-1:0] = ex.imm;
      end
      if (ex.ld_hi) begin
        nxt[WORD_W-1:NIB_W] = ex.imm;
      end
      if (ex.in_en) begin
        nxt = din;
      end
    end
    // ALU results always land in C
    if (ex.alu_en && (self == REG_C)) begin
      nxt = alu_in;
    end
    return nxt;
  endfunction

  always_comb begin
    a_next = next_val(reg_a, REG_A, exec, ui_in, alu_result);
    b_next = next_val(reg_b, REG_B, exec, ui_in, alu_result);
    c_next = next_val(reg_c, REG_C, exec, ui_in, alu_result);
  end

  // OUT source, taken from values before the edge
  always_comb begin
    case (exec.target)
      REG_A:   out_sel = reg_a;
      REG_B:   out_sel = reg_b;
      REG_C:   out_sel = reg_c;
      default: out_sel = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // register file and output register

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      reg_a <= '0;
      reg_b <= '0;
      reg_c <= '0;
    end else begin
      reg_a <= a_next;
      reg_b <= b_next;
      reg_c <= c_next;
    end
  end

  // uo_out holds its value between OUT instructions
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      uo_out <= '0;
    end else if (exec.out_en) begin
      uo_out <= out_sel;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module instr_decoder
  import cpu_pkg::*;
(
  input  word_t instr,
  input  logic  instr_valid,
  output exec_t exec
);

  opcode_e  opcode;
  nib_t     imm;
  reg_sel_e io_sel;

  assign opcode = opcode_e'(instr[WORD_W-1:NIB_W]);
  assign imm    = instr[NIB_W-1:0];

  // register select for IN and OUT, anything past C is invalid
  always_comb begin
    case (imm)
      4'd0:    io_sel = REG_A;
      4'd1:    io_sel = REG_B;
      4'd2:    io_sel = REG_C;
      default: io_sel = REG_NONE;
    endcase
  end

  always_comb begin
    exec        = '0;
    exec.target = REG_NONE;
    if (instr_valid) begin
      case (opcode)
        LDA_LO: begin exec.target = REG_A; exec.ld_lo = 1'b1; end
        LDA_HI: begin exec.target = REG_A; exec.ld_hi = 1'b1; end
        LDB_LO: begin exec.target = REG_B; exec.ld_lo = 1'b1; end
        LDB_HI: begin exec.target = REG_B; exec.ld_hi = 1'b1; end
        LDC_LO: begin exec.target = REG_C; exec.ld_lo = 1'b1; end
        LDC_HI: begin exec.target = REG_C; exec.ld_hi = 1'b1; end
        ADD:    begin exec.target = REG_C; exec.alu_en = 1'b1; exec.alu_op = ALU_ADD; end
        SUB:    begin exec.target = REG_C; exec.alu_en = 1'b1; exec.alu_op = ALU_SUB; end
        MUL:    begin exec.target = REG_C; exec.alu_en = 1'b1; exec.alu_op = ALU_MUL; end
        IN: begin
          exec.target = io_sel;
          exec.in_en  = (io_sel != REG_NONE);
        end
        OUT: begin
          exec.target = io_sel;
          exec.out_en = (io_sel != REG_NONE);
        end
        // NOP and the unassigned codes stay idle
        default: ;
      endcase
      // immediate only matters to the nibble loads
      if (exec.ld_lo || exec.ld_hi) begin
        exec.imm = imm;
      end
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  arst_n,
  input  word_t uio_in,
  input  word_t ui_in,
  output word_t instr,
  output logic  instr_valid
);

  host_ctrl_t host;
  logic       wr_en;
  nib_t       pc;
  word_t      mem [PROG_DEPTH];

  //////////////////////////////////////////////////
  // host pin decode

  // bit 7 is the run level, bits 5:4 = 01 strobe a write to bits 3:0
  always_comb begin
    host.run   = uio_in[7];
    host.write = (uio_in[5:4] == 2'b01);
    host.addr  = uio_in[3:0];
  end

  // program can only be changed while the CPU is stopped
  assign wr_en = host.write && !host.run;

  //////////////////////////////////////////////////
  // program memory

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < PROG_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_en) begin
      mem[host.addr] <= ui_in;
    end
  end

  //////////////////////////////////////////////////
  // program counter

  // 4-bit counter wraps from 15 back to 0 on its own
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= '0;
    end else if (host.run) begin
      pc <= pc + 1'b1;
    end
  end

  // combinational read at the current pc
  assign instr       = mem[pc];
  assign instr_valid = host.run;

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu
  import cpu_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result
);

  word_t sum;
  word_t diff;
  word_t prod;

  //////////////////////////////////////////////////
  // all results wrap modulo 256

  assign sum  = a + b;
  assign diff = a - b;
  // only the low byte of the product is kept
  assign prod = a * b;

  always_comb begin
    case (op)
      ALU_ADD: result = sum;
      ALU_SUB: result = diff;
      ALU_MUL: result = prod;
      default: result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  //////////////////////////////////////////////////
  // widths fixed by the instruction encoding

  localparam int WORD_W     = 8;
  localparam int NIB_W      = 4;
  localparam int PROG_DEPTH = 16;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [NIB_W-1:0]  nib_t;

  //////////////////////////////////////////////////
  // instruction set, upper nibble of each word
  // codes 1100 to 1111 are left unassigned

  typedef enum logic [NIB_W-1:0] {
    NOP    = 4'b0000,
    LDA_LO = 4'b0001,
    LDA_HI = 4'b0010,
    LDB_LO = 4'b0011,
    LDB_HI = 4'b0100,
    LDC_LO = 4'b0101,
    LDC_HI = 4'b0110,
    ADD    = 4'b0111,
    SUB    = 4'b1000,
    MUL    = 4'b1001,
    OUT    = 4'b1010,
    IN     = 4'b1011
  } opcode_e;

  typedef enum logic [1:0] {
    REG_A    = 2'd0,
    REG_B    = 2'd1,
    REG_C    = 2'd2,
    REG_NONE = 2'd3
  } reg_sel_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } alu_op_e;

  //////////////////////////////////////////////////
  // host pins and decoded execute controls

  typedef struct packed {
    logic run;
    logic write;
    nib_t addr;
  } host_ctrl_t;

  // target is the register written by a load or IN, or read by OUT
  typedef struct packed {
    reg_sel_e target;
    logic     ld_lo;
    logic     ld_hi;
    nib_t     imm;
    logic     alu_en;
    alu_op_e  alu_op;
    logic     in_en;
    logic     out_en;
  } exec_t;

endpackage

`default_nettype wire
